//--- rtl/id_pkg.sv
// -------------------------------------
// ID stage package
// Fetch entry, scoreboard entry, unit, operation,
// opcode and exception cause definitions
// -------------------------------------
package id_pkg;

  parameter int unsigned XLEN     = 32;
  parameter int unsigned RegAddrW = 5;

  // Word handed over by the fetch stage
  typedef struct packed {
    logic [XLEN-1:0] address;
    logic [31:0]     instruction;
    // Fetch page fault
    logic            ex_valid;
  } fetch_entry_t;

  typedef enum logic [2:0] {
    FU_NONE,
    FU_ALU,
    FU_BRANCH,
    FU_LOAD,
    FU_STORE,
    FU_CTRL_FLOW
  } fu_t;

  typedef enum logic [4:0] {
    // ALU
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    // Branch compares
    OP_EQ, OP_NE, OP_LTS, OP_GES, OP_LTU, OP_GEU,
    // Memory
    OP_LW, OP_SW,
    // Jumps and upper immediates
    OP_JAL, OP_JALR, OP_LUI, OP_AUIPC
  } op_t;

  // Major opcodes of the base instruction set
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_t;

  // Cause codes as in mcause, zero when nothing is raised
  typedef enum logic [3:0] {
    EXC_NONE             = 4'd0,
    EXC_ILLEGAL_INSTR    = 4'd2,
    EXC_INSTR_PAGE_FAULT = 4'd12
  } exc_cause_t;

  typedef struct packed {
    logic [XLEN-1:0]     pc;
    fu_t                 fu;
    op_t                 op;
    logic [RegAddrW-1:0] rs1;
    logic [RegAddrW-1:0] rs2;
    logic [RegAddrW-1:0] rd;
    logic [XLEN-1:0]     imm;
    logic                use_imm;
    logic                is_compressed;
    logic                ex_valid;
    exc_cause_t          ex_cause;
  } sb_entry_t;

  // Expander result towards the decoder
  typedef struct packed {
    logic [31:0] instruction;
    logic        is_compressed;
    logic        illegal;
  } expanded_t;

endpackage

//--- rtl/compressed_expander.sv
// -------------------------------------
// Compressed expander
// Maps supported RVC forms onto their 32-bit
// equivalents, flags every other 16-bit form
// -------------------------------------
`timescale 1ns/1ps

module compressed_expander import id_pkg::*; #(
  parameter bit RvcEn = 1'b1
) (
  input  logic [31:0] instr_i,
  output expanded_t   expanded_o
);

  logic                is_compressed;
  logic [2:0]          c_funct3;
  logic [RegAddrW-1:0] rd_full;
  logic [RegAddrW-1:0] rs2_full;
  // Compact register fields address x8 to x15
  logic [RegAddrW-1:0] rd_prime;
  logic [RegAddrW-1:0] rs1_prime;

  assign is_compressed = (instr_i[1:0] != 2'b11);
  assign c_funct3      = instr_i[15:13];
  assign rd_full       = instr_i[11:7];
  assign rs2_full      = instr_i[6:2];
  assign rd_prime      = {2'b01, instr_i[4:2]};
  assign rs1_prime     = {2'b01, instr_i[9:7]};

  always_comb begin
    expanded_o.instruction   = instr_i;
    expanded_o.is_compressed = is_compressed;
    expanded_o.illegal       = 1'b0;

    if (is_compressed) begin
      if (!RvcEn) begin
        expanded_o.illegal = 1'b1;
      end else begin
        case (instr_i[1:0])
          // -------------------------------------
          // Quadrant 0
          // -------------------------------------
          2'b00: begin
            case (c_funct3)
              // C.LW -> lw rd', uimm(rs1')
              3'b010: begin
                expanded_o.instruction = {5'b0, instr_i[5], instr_i[12:10], instr_i[6],
                                          2'b00, rs1_prime, 3'b010, rd_prime, OPC_LOAD};
              end
              // C.SW -> sw rs2', uimm(rs1')
              3'b110: begin
                expanded_o.instruction = {5'b0, instr_i[5], instr_i[12], rd_prime,
                                          rs1_prime, 3'b010, instr_i[11:10], instr_i[6],
                                          2'b00, OPC_STORE};
              end
              default: expanded_o.illegal = 1'b1;
            endcase
          end
          // -------------------------------------
          // Quadrant 1
          // -------------------------------------
          2'b01: begin
            case (c_funct3)
              // C.ADDI -> addi rd, rd, imm
              3'b000: begin
                expanded_o.instruction = {{7{instr_i[12]}}, instr_i[6:2], rd_full, 3'b000,
                                          rd_full, OPC_OP_IMM};
              end
              // C.LI -> addi rd, x0, imm
              3'b010: begin
                expanded_o.instruction = {{7{instr_i[12]}}, instr_i[6:2], 5'b0, 3'b000,
                                          rd_full, OPC_OP_IMM};
              end
              // C.J -> jal x0, offset
              3'b101: begin
                expanded_o.instruction = {instr_i[12], instr_i[8], instr_i[10:9],
                                          instr_i[6], instr_i[7], instr_i[2], instr_i[11],
                                          instr_i[5:3], instr_i[12], {8{instr_i[12]}},
                                          5'b0, OPC_JAL};
              end
              // C.BEQZ -> beq rs1', x0, offset
              3'b110: begin
                expanded_o.instruction = {{4{instr_i[12]}}, instr_i[6:5], instr_i[2],
                                          5'b0, rs1_prime, 3'b000, instr_i[11:10],
                                          instr_i[4:3], instr_i[12], OPC_BRANCH};
              end
              default: expanded_o.illegal = 1'b1;
            endcase
          end
          // -------------------------------------
          // Quadrant 2
          // -------------------------------------
          2'b10: begin
            // rs2 of zero selects C.JR, C.JALR or C.EBREAK, none supported
            if (c_funct3 == 3'b100 && rs2_full != '0) begin
              if (instr_i[12]) begin
                // C.ADD -> add rd, rd, rs2
                expanded_o.instruction = {7'b0, rs2_full, rd_full, 3'b000, rd_full, OPC_OP};
              end else begin
                // C.MV -> add rd, x0, rs2
                expanded_o.instruction = {7'b0, rs2_full, 5'b0, 3'b000, rd_full, OPC_OP};
              end
            end else begin
              expanded_o.illegal = 1'b1;
            end
          end
          default: expanded_o.illegal = 1'b1;
        endcase
      end
    end
  end

endmodule

//--- rtl/instr_decoder.sv
// -------------------------------------
// Instruction decoder
// Turns a 32-bit instruction into a scoreboard entry
// -------------------------------------
`timescale 1ns/1ps

module instr_decoder import id_pkg::*; (
  input  logic [XLEN-1:0] pc_i,
  input  logic            fetch_ex_i,
  input  expanded_t       expanded_i,
  output sb_entry_t       entry_o,
  output logic            is_ctrl_flow_o
);

  logic [31:0]     instr;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            illegal;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign instr  = expanded_i.instruction;
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // -------------------------------------
  // Immediate formats
  // -------------------------------------
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    entry_o.pc            = pc_i;
    entry_o.fu            = FU_NONE;
    entry_o.op            = OP_ADD;
    entry_o.rs1           = '0;
    entry_o.rs2           = '0;
    entry_o.rd            = '0;
    entry_o.imm           = '0;
    entry_o.use_imm       = 1'b0;
    entry_o.is_compressed = expanded_i.is_compressed;
    entry_o.ex_valid      = 1'b0;
    entry_o.ex_cause      = EXC_NONE;
    illegal               = expanded_i.illegal;

    case (instr[6:0])
      OPC_LUI, OPC_AUIPC: begin
        entry_o.fu      = FU_ALU;
        entry_o.op      = (instr[6:0] == OPC_LUI) ? OP_LUI : OP_AUIPC;
        entry_o.rd      = instr[11:7];
        entry_o.imm     = imm_u;
        entry_o.use_imm = 1'b1;
      end
      OPC_JAL: begin
        entry_o.fu      = FU_CTRL_FLOW;
        entry_o.op      = OP_JAL;
        entry_o.rd      = instr[11:7];
        entry_o.imm     = imm_j;
        entry_o.use_imm = 1'b1;
      end
      OPC_JALR: begin
        entry_o.fu      = FU_CTRL_FLOW;
        entry_o.op      = OP_JALR;
        entry_o.rs1     = instr[19:15];
        entry_o.rd      = instr[11:7];
        entry_o.imm     = imm_i;
        entry_o.use_imm = 1'b1;
        if (funct3 != 3'b000) illegal = 1'b1;
      end
      // Compares rs1 with rs2, the immediate is the target offset
      OPC_BRANCH: begin
        entry_o.fu  = FU_BRANCH;
        entry_o.rs1 = instr[19:15];
        entry_o.rs2 = instr[24:20];
        entry_o.imm = imm_b;
        case (funct3)
          3'b000:  entry_o.op = OP_EQ;
          3'b001:  entry_o.op = OP_NE;
          3'b100:  entry_o.op = OP_LTS;
          3'b101:  entry_o.op = OP_GES;
          3'b110:  entry_o.op = OP_LTU;
          3'b111:  entry_o.op = OP_GEU;
          default: illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        entry_o.fu      = FU_LOAD;
        entry_o.op      = OP_LW;
        entry_o.rs1     = instr[19:15];
        entry_o.rd      = instr[11:7];
        entry_o.imm     = imm_i;
        entry_o.use_imm = 1'b1;
        if (funct3 != 3'b010) illegal = 1'b1;
      end
      OPC_STORE: begin
        entry_o.fu  = FU_STORE;
        entry_o.op  = OP_SW;
        entry_o.rs1 = instr[19:15];
        entry_o.rs2 = instr[24:20];
        entry_o.imm = imm_s;
        if (funct3 != 3'b010) illegal = 1'b1;
      end
      OPC_OP_IMM: begin
        entry_o.fu      = FU_ALU;
        entry_o.rs1     = instr[19:15];
        entry_o.rd      = instr[11:7];
        entry_o.imm     = imm_i;
        entry_o.use_imm = 1'b1;
        case (funct3)
          3'b000: entry_o.op = OP_ADD;
          3'b010: entry_o.op = OP_SLT;
          3'b011: entry_o.op = OP_SLTU;
          3'b100: entry_o.op = OP_XOR;
          3'b110: entry_o.op = OP_OR;
          3'b111: entry_o.op = OP_AND;
          3'b001: begin
            entry_o.op = OP_SLL;
            if (funct7 != 7'b0000000) illegal = 1'b1;
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            if (funct7 == 7'b0000000) entry_o.op = OP_SRL;
            else if (funct7 == 7'b0100000) entry_o.op = OP_SRA;
            else illegal = 1'b1;
          end
        endcase
      end
      OPC_OP: begin
        entry_o.fu  = FU_ALU;
        entry_o.rs1 = instr[19:15];
        entry_o.rs2 = instr[24:20];
        entry_o.rd  = instr[11:7];
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  entry_o.op = OP_ADD;
            3'b001:  entry_o.op = OP_SLL;
            3'b010:  entry_o.op = OP_SLT;
            3'b011:  entry_o.op = OP_SLTU;
            3'b100:  entry_o.op = OP_XOR;
            3'b101:  entry_o.op = OP_SRL;
            3'b110:  entry_o.op = OP_OR;
            default: entry_o.op = OP_AND;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          entry_o.op = OP_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          entry_o.op = OP_SRA;
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase

    // Any exception leaves an entry with no unit and no operands
    if (fetch_ex_i || illegal) begin
      entry_o.fu       = FU_NONE;
      entry_o.op       = OP_ADD;
      entry_o.rs1      = '0;
      entry_o.rs2      = '0;
      entry_o.rd       = '0;
      entry_o.imm      = '0;
      entry_o.use_imm  = 1'b0;
      entry_o.ex_valid = 1'b1;
      // The page fault wins, the word itself is not trustworthy
      if (fetch_ex_i) entry_o.ex_cause = EXC_INSTR_PAGE_FAULT;
      else entry_o.ex_cause = EXC_ILLEGAL_INSTR;
    end
  end

  assign is_ctrl_flow_o = (entry_o.fu == FU_BRANCH) || (entry_o.fu == FU_CTRL_FLOW);

endmodule

//--- rtl/issue_register.sv
// -------------------------------------
// ID/issue register
// One-deep holding stage with valid, ack and flush
// -------------------------------------
`timescale 1ns/1ps

module issue_register import id_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  input  logic        valid_i,
  output logic        ready_o,
  input  sb_entry_t   entry_i,
  input  logic        ctrl_flow_i,
  input  logic [31:0] orig_instr_i,
  input  logic        ack_i,
  output sb_entry_t   entry_o,
  output logic        valid_o,
  output logic        ctrl_flow_o,
  output logic [31:0] orig_instr_o
);

  // Everything that moves together from decode to issue
  typedef struct packed {
    sb_entry_t   sbe;
    logic [31:0] orig_instr;
    logic        ctrl_flow;
  } issue_t;

  issue_t issue_q;
  logic   valid_q;
  logic   valid_d;

  // Take a new word when empty or when the held one leaves this cycle
  assign ready_o = valid_i && !flush_i && (!valid_q || ack_i);

  always_comb begin
    valid_d = valid_q;
    if (ack_i) valid_d = 1'b0;
    if (ready_o) valid_d = 1'b1;
    if (flush_i) valid_d = 1'b0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // Payload only moves on acceptance
  always_ff @(posedge clk_i) begin
    if (ready_o) begin
      issue_q <= '{sbe: entry_i, orig_instr: orig_instr_i, ctrl_flow: ctrl_flow_i};
    end
  end

  assign entry_o      = issue_q.sbe;
  assign orig_instr_o = issue_q.orig_instr;
  assign valid_o      = valid_q;
  // A stale flag from a dropped entry must not show
  assign ctrl_flow_o  = valid_q && issue_q.ctrl_flow;

endmodule

//--- rtl/id_stage.sv
// -------------------------------------
// Instruction decode stage
// Expands, decodes and registers one fetch entry
// -------------------------------------
`timescale 1ns/1ps

module id_stage import id_pkg::*; #(
  parameter bit RvcEn = 1'b1
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  // Fetch side
  input  fetch_entry_t fetch_entry_i,
  input  logic         fetch_entry_valid_i,
  output logic         fetch_entry_ready_o,
  // Issue side
  output sb_entry_t    issue_entry_o,
  output logic         issue_valid_o,
  output logic         is_ctrl_flow_o,
  output logic [31:0]  orig_instr_o,
  input  logic         issue_ack_i
);

  expanded_t expanded;
  sb_entry_t decoded;
  logic      decoded_ctrl_flow;

  compressed_expander #(
    .RvcEn(RvcEn)
  ) i_compressed_expander (
    .instr_i   (fetch_entry_i.instruction),
    .expanded_o(expanded)
  );

  instr_decoder i_instr_decoder (
    .pc_i          (fetch_entry_i.address),
    .fetch_ex_i    (fetch_entry_i.ex_valid),
    .expanded_i    (expanded),
    .entry_o       (decoded),
    .is_ctrl_flow_o(decoded_ctrl_flow)
  );

  // The raw fetch word is kept, not the expanded one
  issue_register i_issue_register (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .valid_i     (fetch_entry_valid_i),
    .ready_o     (fetch_entry_ready_o),
    .entry_i     (decoded),
    .ctrl_flow_i (decoded_ctrl_flow),
    .orig_instr_i(fetch_entry_i.instruction),
    .ack_i       (issue_ack_i),
    .entry_o     (issue_entry_o),
    .valid_o     (issue_valid_o),
    .ctrl_flow_o (is_ctrl_flow_o),
    .orig_instr_o(orig_instr_o)
  );

endmodule

//--- tests/tb_ref_model.svh
// ----------------------------------------
// ID stage reference model
// Expected expansion and scoreboard entry
// ----------------------------------------
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Returns 0 for a compressed form that is not supported
function automatic logic ref_expand(input logic [15:0] c, output logic [31:0] x);
  logic [11:0] imm;
  logic [20:0] jo;
  logic [12:0] bo;
  logic [4:0]  rdp;
  logic [4:0]  rsp;
  rdp = {2'b01, c[4:2]};
  rsp = {2'b01, c[9:7]};
  imm = {{6{c[12]}}, c[12], c[6:2]};
  x = 32'h0;
  case ({c[15:13], c[1:0]})
    5'b010_00: begin
      imm = {5'b0, c[5], c[12:10], c[6], 2'b00};
      x = {imm, rsp, 3'b010, rdp, 7'b0000011};
    end
    5'b110_00: begin
      imm = {5'b0, c[5], c[12:10], c[6], 2'b00};
      x = {imm[11:5], rdp, rsp, 3'b010, imm[4:0], 7'b0100011};
    end
    5'b000_01: x = {imm, c[11:7], 3'b000, c[11:7], 7'b0010011};
    5'b010_01: x = {imm, 5'b0, 3'b000, c[11:7], 7'b0010011};
    5'b101_01: begin
      jo = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
      x = {jo[20], jo[10:1], jo[11], jo[19:12], 5'b0, 7'b1101111};
    end
    5'b110_01: begin
      bo = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
      x = {bo[12], bo[10:5], 5'b0, rsp, 3'b000, bo[4:1], bo[11], 7'b1100011};
    end
    5'b100_10: begin
      if (c[6:2] == 5'b0) return 1'b0;
      x = {7'b0, c[6:2], (c[12] ? c[11:7] : 5'b0), 3'b000, c[11:7], 7'b0110011};
    end
    default: return 1'b0;
  endcase
  return 1'b1;
endfunction

function automatic op_t ref_alu_op(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0: return alt ? OP_SUB : OP_ADD;
    3'd1: return OP_SLL;
    3'd2: return OP_SLT;
    3'd3: return OP_SLTU;
    3'd4: return OP_XOR;
    3'd5: return alt ? OP_SRA : OP_SRL;
    3'd6: return OP_OR;
    default: return OP_AND;
  endcase
endfunction

function automatic sb_entry_t ref_entry(input logic [31:0] w, input logic [31:0] pc,
                                        input logic fault);
  sb_entry_t   e;
  logic [31:0] x;
  logic        bad;
  logic [2:0]  f3;
  logic [6:0]  f7;
  e = '0;
  e.pc = pc;
  e.is_compressed = (w[1:0] != 2'b11);
  x = w;
  bad = 1'b0;
  if (e.is_compressed) bad = !ref_expand(w[15:0], x);
  f3 = x[14:12];
  f7 = x[31:25];
  case (x[6:0])
    7'b0110111, 7'b0010111: begin
      e.fu = FU_ALU;
      e.op = x[5] ? OP_LUI : OP_AUIPC;
      e.rd = x[11:7];
      e.imm = {x[31:12], 12'b0};
      e.use_imm = 1'b1;
    end
    7'b1101111: begin
      e.fu = FU_CTRL_FLOW;
      e.op = OP_JAL;
      e.rd = x[11:7];
      e.imm = {{12{x[31]}}, x[19:12], x[20], x[30:21], 1'b0};
      e.use_imm = 1'b1;
    end
    7'b1100111, 7'b0000011, 7'b0010011: begin
      e.fu = (x[6:0] == 7'b1100111) ? FU_CTRL_FLOW :
             (x[6:0] == 7'b0000011) ? FU_LOAD : FU_ALU;
      e.op = (x[6:0] == 7'b1100111) ? OP_JALR :
             (x[6:0] == 7'b0000011) ? OP_LW : ref_alu_op(f3, f3 == 3'd5 && f7[5]);
      e.rs1 = x[19:15];
      e.rd = x[11:7];
      e.imm = {{20{x[31]}}, x[31:20]};
      e.use_imm = 1'b1;
      if (x[6:0] == 7'b1100111) bad |= (f3 != 3'd0);
      else if (x[6:0] == 7'b0000011) bad |= (f3 != 3'd2);
      else if (f3 == 3'd1) bad |= (f7 != 7'h00);
      else if (f3 == 3'd5) bad |= (f7 != 7'h00 && f7 != 7'h20);
    end
    7'b1100011, 7'b0100011: begin
      e.fu = x[6] ? FU_BRANCH : FU_STORE;
      e.rs1 = x[19:15];
      e.rs2 = x[24:20];
      if (x[6]) begin
        e.imm = {{20{x[31]}}, x[7], x[30:25], x[11:8], 1'b0};
        bad |= (f3[2:1] == 2'b01);
        e.op = op_t'(OP_EQ + (f3[2] ? f3 - 3'd2 : f3));
      end else begin
        e.imm = {{20{x[31]}}, x[31:25], x[11:7]};
        e.op = OP_SW;
        bad |= (f3 != 3'd2);
      end
    end
    7'b0110011: begin
      e.fu = FU_ALU;
      e.rs1 = x[19:15];
      e.rs2 = x[24:20];
      e.rd = x[11:7];
      e.op = ref_alu_op(f3, f7 == 7'h20);
      bad |= !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
    end
    default: bad = 1'b1;
  endcase
  if (bad || fault) begin
    e = '0;
    e.pc = pc;
    e.is_compressed = (w[1:0] != 2'b11);
    e.ex_valid = 1'b1;
    e.ex_cause = fault ? EXC_INSTR_PAGE_FAULT : EXC_ILLEGAL_INSTR;
  end
  return e;
endfunction

`endif

//--- tests/tb_id_stage.sv
// ----------------------------------------
// ID stage testbench
// Random instructions under back-pressure
// and flush, checked against a reference
// ----------------------------------------
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ;

  `include "tb_ref_model.svh"

  localparam int NTESTS = 2000;

  typedef struct packed {
    sb_entry_t   sbe;
    logic [31:0] orig;
    logic        cf;
  } exp_t;

  logic         clk_i = 1'b0;
  logic         rst_ni;
  logic         flush_i;
  fetch_entry_t fetch_entry_i;
  logic         fetch_entry_valid_i;
  logic         fetch_entry_ready_o;
  sb_entry_t    issue_entry_o;
  logic         issue_valid_o;
  logic         is_ctrl_flow_o;
  logic [31:0]  orig_instr_o;
  logic         issue_ack_i;

  exp_t        exp_q[$];
  exp_t        got;
  exp_t        want;
  exp_t        held;
  logic        hold_prev = 1'b0;
  logic        valid_next = 1'b0;
  int          errors = 0;
  int          issued = 0;

  id_stage #(.RvcEn(1'b1)) dut0 (.*);

  always #4 clk_i = ~clk_i;

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("** Error %0t: %s got %h expected %h", $time, name, act, exp);
      errors++;
    end
  endtask

  // Random fields dropped into one template per supported class
  function automatic logic [31:0] gen_instr();
    logic [31:0] r;
    r = $urandom;
    case ($urandom % 17)
      0: return {r[31:7], 7'b0110111};
      1: return {r[31:7], 7'b0010111};
      2: return {r[31:7], 7'b1101111};
      3: return {r[31:15], 3'b000, r[11:7], 7'b1100111};
      4: return {r[31:7], 7'b1100011};
      5: return {r[31:15], 3'b010, r[11:7], 7'b0000011};
      6: return {r[31:15], 3'b010, r[11:7], 7'b0100011};
      7: return {r[31:7], 7'b0010011};
      8: return {1'b0, r[30], 5'b0, r[24:7], 7'b0110011};
      9: return {r[31:16], 3'b000, r[12:2], 2'b01};
      10: return {r[31:16], 3'b010, r[12:2], 2'b01};
      11: return {r[31:16], 3'b100, r[12:2], 2'b10};
      12: return {r[31:16], 3'b101, r[12:2], 2'b01};
      13: return {r[31:16], 3'b110, r[12:2], 2'b01};
      14: return {r[31:16], 3'b010, r[12:2], 2'b00};
      15: return {r[31:16], 3'b110, r[12:2], 2'b00};
      default: return r;
    endcase
  endfunction

  // ----------------------------------------
  // Monitor and checker sampled mid-cycle
  // ----------------------------------------
  always @(negedge clk_i) begin
    if (rst_ni) begin
      got = '{sbe: issue_entry_o, orig: orig_instr_o, cf: is_ctrl_flow_o};
      check("issue_valid_o", issue_valid_o, valid_next);
      check("fetch_entry_ready_o", fetch_entry_ready_o,
            fetch_entry_valid_i && !flush_i && (!valid_next || issue_ack_i));
      // Held entry must not move while stalled
      if (hold_prev && issue_valid_o) check("held entry", 32'(got != held), 32'h0);
      if (issue_valid_o && issue_ack_i) begin
        if (exp_q.size() == 0) begin
          $display("Entry issued with nothing accepted before it");
          errors++;
        end else begin
          want = exp_q.pop_front();
          issued++;
          check("pc", got.sbe.pc, want.sbe.pc);
          check("fu", got.sbe.fu, want.sbe.fu);
          check("op", got.sbe.op, want.sbe.op);
          check("rs1", got.sbe.rs1, want.sbe.rs1);
          check("rs2", got.sbe.rs2, want.sbe.rs2);
          check("rd", got.sbe.rd, want.sbe.rd);
          check("imm", got.sbe.imm, want.sbe.imm);
          check("use_imm", got.sbe.use_imm, want.sbe.use_imm);
          check("is_compressed", got.sbe.is_compressed, want.sbe.is_compressed);
          check("ex_valid", got.sbe.ex_valid, want.sbe.ex_valid);
          check("ex_cause", got.sbe.ex_cause, want.sbe.ex_cause);
          check("is_ctrl_flow_o", got.cf, want.cf);
          check("orig_instr_o", got.orig, want.orig);
        end
      end else if (issue_valid_o && flush_i && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (fetch_entry_valid_i && fetch_entry_ready_o) begin
        want.sbe = ref_entry(fetch_entry_i.instruction, fetch_entry_i.address,
                             fetch_entry_i.ex_valid);
        want.orig = fetch_entry_i.instruction;
        // Jumps and branches that raise nothing
        want.cf = !want.sbe.ex_valid &&
                  (want.sbe.op inside {OP_JAL, OP_JALR, OP_EQ, OP_NE, OP_LTS, OP_GES,
                                       OP_LTU, OP_GEU});
        exp_q.push_back(want);
      end
      hold_prev = issue_valid_o && !issue_ack_i && !flush_i;
      held = got;
      valid_next = !flush_i && ((fetch_entry_valid_i && fetch_entry_ready_o) ||
                                (issue_valid_o && !issue_ack_i));
    end
  end

  initial begin
    #(NTESTS * 20 * 8);
    $display("Timeout, the run did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'hd93054b9));
    rst_ni = 1'b0;
    flush_i = 1'b0;
    fetch_entry_i = '0;
    fetch_entry_valid_i = 1'b0;
    issue_ack_i = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check("issue_valid_o after reset", issue_valid_o, 1'b0);
    check("fetch_entry_ready_o after reset", fetch_entry_ready_o, 1'b0);
    check("is_ctrl_flow_o after reset", is_ctrl_flow_o, 1'b0);
    for (int i = 0; i < NTESTS; i++) begin
      @(posedge clk_i);
      fetch_entry_valid_i <= ($urandom % 4) != 0;
      fetch_entry_i <= '{address: $urandom & 32'hffff_fffe, instruction: gen_instr(),
                         ex_valid: ($urandom % 32) == 0};
      issue_ack_i <= valid_next && ($urandom % 3 != 0);
      flush_i <= ($urandom % 24) == 0;
    end
    @(posedge clk_i);
    fetch_entry_valid_i <= 1'b0;
    flush_i <= 1'b0;
    issue_ack_i <= valid_next;
    // Drain the entry still held
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      issue_ack_i <= valid_next;
    end
    @(posedge clk_i);
    issue_ack_i <= 1'b0;
    if (issued == 0) begin
      $display("No entry was ever issued");
      errors++;
    end
    $display("Issued %0d entries, %0d errors", issued, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
rtl/id_pkg.sv
rtl/compressed_expander.sv
rtl/instr_decoder.sv
rtl/issue_register.sv
rtl/id_stage.sv
+incdir+tests
tests/tb_id_stage.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := tb_id_stage
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log for a pass"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^>>> PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
